//--- procPkg.sv
`default_nettype none

package procPkg;

  // Word and register index widths
  localparam int DataWidth    = 16;
  localparam int RegAddrWidth = 3;

  typedef logic [DataWidth-1:0]    wordT;
  typedef logic [RegAddrWidth-1:0] regAddrT;

  // Opcodes live in instruction bits 15 to 11
  typedef enum logic [4:0] {
    OpHalt  = 5'b00000,
    OpNop   = 5'b00001,
    OpJ     = 5'b00100,
    OpAddi  = 5'b01000,
    OpSubi  = 5'b01001,
    OpXori  = 5'b01010,
    OpAndni = 5'b01011,
    OpBeqz  = 5'b01100,
    OpBnez  = 5'b01101,
    OpSt    = 5'b10000,
    OpLd    = 5'b10001,
    OpRtype = 5'b11011,
    OpSlt   = 5'b11100
  } opcodeT;

  // Function field of register ops, bits 1 to 0
  typedef enum logic [1:0] {
    FnAdd  = 2'b00,
    FnSub  = 2'b01,
    FnXor  = 2'b10,
    FnAndn = 2'b11
  } functT;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluXor,
    AluAndn,
    AluSlt,
    AluPassB
  } aluOpT;

endpackage

`default_nettype wire

//--- instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch #(
  parameter int ImemDepth = 256
) (
  input  wire logic          clk,
  input  wire logic          arstN,
  input  procPkg::wordT      nextPc,
  input  wire logic          stop,
  input  wire logic          imemWe,
  input  procPkg::wordT      imemAddr,
  input  procPkg::wordT      imemData,
  output procPkg::wordT      pc,
  output procPkg::wordT      instruction,
  output logic               halted
);

  localparam int ImemAw = $clog2(ImemDepth);

  procPkg::wordT imem [ImemDepth];

  // PC freezes once the core stops
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (!halted) begin
      if (stop) begin
        halted <= 1'b1;
      end else begin
        pc <= nextPc;
      end
    end
  end

  // Program load port, written while the core sits in reset
  always_ff @(posedge clk) begin
    if (imemWe && imemAddr < ImemDepth) begin
      imem[imemAddr[ImemAw-1:0]] <= imemData;
    end
  end

  // Fetch past the end of the memory sees a NOP
  assign instruction = (pc < ImemDepth) ? imem[pc[ImemAw-1:0]]
                                        : {procPkg::OpNop, 11'd0};

  imemLoadInReset: assert property (@(posedge clk) imemWe |-> !arstN);

endmodule

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
  input  wire logic        clk,
  input  wire logic        arstN,
  input  procPkg::wordT    instruction,
  input  wire logic        regWrite,
  input  wire logic        regDst,
  input  procPkg::wordT    writeData,
  output procPkg::wordT    rsData,
  output procPkg::wordT    rtData,
  output procPkg::wordT    immExt,
  output procPkg::wordT    jumpTarget,
  output procPkg::regAddrT wbAddr
);

  procPkg::wordT    regs [2**procPkg::RegAddrWidth];
  procPkg::opcodeT  opcode;
  procPkg::regAddrT rsAddr;
  procPkg::regAddrT rtAddr;

  assign opcode = procPkg::opcodeT'(instruction[15:11]);
  assign rsAddr = instruction[10:8];
  assign rtAddr = instruction[7:5];

  // R-type writes rd in bits 4:2, I-type writes rd in bits 7:5
  assign wbAddr = regDst ? procPkg::regAddrT'(instruction[4:2]) : rtAddr;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regs <= '{default: '0};
    end else if (regWrite) begin
      regs[wbAddr] <= writeData;
    end
  end

  // Combinational reads, new value visible after the write edge
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];

  // Branches carry an 8-bit offset, everything else a 5-bit immediate
  always_comb begin
    if (opcode == procPkg::OpBeqz || opcode == procPkg::OpBnez) begin
      immExt = {{(procPkg::DataWidth-8){instruction[7]}}, instruction[7:0]};
    end else begin
      immExt = {{(procPkg::DataWidth-5){instruction[4]}}, instruction[4:0]};
    end
  end

  // Jump displacement, added to PC plus one in execute
  assign jumpTarget = {{(procPkg::DataWidth-11){instruction[10]}}, instruction[10:0]};

endmodule

`default_nettype wire

//--- control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
  input  procPkg::wordT  instruction,
  output logic           regWrite,
  output logic           regDst,
  output logic           aluSrc,
  output logic           memRead,
  output logic           memWrite,
  output logic           memToReg,
  output logic           branch,
  output logic           branchOnZero,
  output logic           jump,
  output logic           halt,
  output procPkg::aluOpT aluOp,
  output logic           ctrlErr
);

  procPkg::opcodeT opcode;
  procPkg::functT  funct;

  assign opcode = procPkg::opcodeT'(instruction[15:11]);
  assign funct  = procPkg::functT'(instruction[1:0]);

  always_comb begin
    // Defaults describe a NOP
    regWrite     = 1'b0;
    regDst       = 1'b0;
    aluSrc       = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    memToReg     = 1'b0;
    branch       = 1'b0;
    branchOnZero = 1'b0;
    jump         = 1'b0;
    halt         = 1'b0;
    aluOp        = procPkg::AluPassB;
    ctrlErr      = 1'b0;

    case (opcode)
      procPkg::OpHalt: halt = 1'b1;
      procPkg::OpNop:  ;
      procPkg::OpJ:    jump = 1'b1;
      procPkg::OpAddi, procPkg::OpSubi, procPkg::OpXori, procPkg::OpAndni: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        // Low two opcode bits pick the operation
        case (opcode[1:0])
          2'b00:   aluOp = procPkg::AluAdd;
          2'b01:   aluOp = procPkg::AluSub;
          2'b10:   aluOp = procPkg::AluXor;
          default: aluOp = procPkg::AluAndn;
        endcase
      end
      procPkg::OpBeqz: begin
        branch       = 1'b1;
        branchOnZero = 1'b1;
      end
      procPkg::OpBnez: branch = 1'b1;
      procPkg::OpSt: begin
        aluSrc   = 1'b1;
        aluOp    = procPkg::AluAdd;
        memWrite = 1'b1;
      end
      procPkg::OpLd: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        aluOp    = procPkg::AluAdd;
        memRead  = 1'b1;
        memToReg = 1'b1;
      end
      procPkg::OpRtype: begin
        regWrite = 1'b1;
        regDst   = 1'b1;
        case (funct)
          procPkg::FnAdd: aluOp = procPkg::AluAdd;
          procPkg::FnSub: aluOp = procPkg::AluSub;
          procPkg::FnXor: aluOp = procPkg::AluXor;
          default:        aluOp = procPkg::AluAndn;
        endcase
      end
      procPkg::OpSlt: begin
        regWrite = 1'b1;
        regDst   = 1'b1;
        aluOp    = procPkg::AluSlt;
      end
      // Unknown opcode, no writes of any kind
      default: ctrlErr = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  procPkg::aluOpT aluOp,
  input  wire logic      aluSrc,
  input  procPkg::wordT  rsData,
  input  procPkg::wordT  rtData,
  input  procPkg::wordT  immExt,
  input  procPkg::wordT  jumpTarget,
  input  wire logic      jump,
  input  procPkg::wordT  pc,
  output procPkg::wordT  aluResult,
  output logic           zero,
  output procPkg::wordT  branchTarget
);

  procPkg::wordT opB;
  procPkg::wordT pcPlusOne;
  procPkg::wordT offset;

  // Operand B is the immediate for I-type, LD and ST
  assign opB = aluSrc ? immExt : rtData;

  always_comb begin
    case (aluOp)
      procPkg::AluAdd:  aluResult = rsData + opB;
      procPkg::AluSub:  aluResult = rsData - opB;
      procPkg::AluXor:  aluResult = rsData ^ opB;
      procPkg::AluAndn: aluResult = rsData & ~opB;
      procPkg::AluSlt: begin
        // Signed compare of rs against rt
        if ($signed(rsData) < $signed(opB)) begin
          aluResult = procPkg::wordT'(1);
        end else begin
          aluResult = '0;
        end
      end
      default:          aluResult = opB;
    endcase
  end

  // Branches test rs against zero
  assign zero = (rsData == '0);

  assign pcPlusOne    = pc + procPkg::wordT'(1);
  assign offset       = jump ? jumpTarget : immExt;
  assign branchTarget = pcPlusOne + offset;

endmodule

`default_nettype wire

//--- dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int DmemDepth = 256
) (
  input  wire logic     clk,
  input  wire logic     memRead,
  input  wire logic     memWrite,
  input  procPkg::wordT addr,
  input  procPkg::wordT writeData,
  input  wire logic     branch,
  input  wire logic     branchOnZero,
  input  wire logic     zero,
  output procPkg::wordT readData,
  output logic          takeBranch,
  output logic          memErr
);

  localparam int DmemAw = $clog2(DmemDepth);

  procPkg::wordT mem [DmemDepth];
  logic          inRange;

  assign inRange = (addr < DmemDepth);
  assign memErr  = (memRead || memWrite) && !inRange;

  // Out-of-range stores are dropped
  always_ff @(posedge clk) begin
    if (memWrite && inRange) begin
      mem[addr[DmemAw-1:0]] <= writeData;
    end
  end

  assign readData = inRange ? mem[addr[DmemAw-1:0]] : '0;

  // BEQZ wants zero set, BNEZ wants it clear
  assign takeBranch = branch && (zero == branchOnZero);

  // Control never asks for a load and a store in the same instruction
  memPortExclusive: assert property (@(posedge clk) !(memRead && memWrite));

endmodule

`default_nettype wire

//--- writeBack.sv
`timescale 1ns/1ps
`default_nettype none

module writeBack (
  input  wire logic     memToReg,
  input  procPkg::wordT readData,
  input  procPkg::wordT aluResult,
  input  procPkg::wordT pc,
  input  procPkg::wordT branchTarget,
  input  wire logic     takeBranch,
  input  wire logic     jump,
  output procPkg::wordT wbData,
  output procPkg::wordT nextPc
);

  // Loads write memory data, everything else the ALU result
  assign wbData = memToReg ? readData : aluResult;

  // Sequential flow unless a branch is taken or a jump redirects
  assign nextPc = (takeBranch || jump) ? branchTarget : pc + procPkg::wordT'(1);

endmodule

`default_nettype wire

//--- proc.sv
`timescale 1ns/1ps
`default_nettype none

module proc #(
  parameter int ImemDepth = 256,
  parameter int DmemDepth = 256
) (
  input  wire logic          clk,
  input  wire logic          arstN,
  input  wire logic          imemWe,
  input  procPkg::wordT      imemAddr,
  input  procPkg::wordT      imemData,
  output logic               commitValid,
  output procPkg::wordT      commitPc,
  output procPkg::wordT      commitInstr,
  output logic               wbEn,
  output procPkg::regAddrT   wbAddr,
  output procPkg::wordT      wbData,
  output logic               halted,
  output logic               err
);

  procPkg::wordT  pc;
  procPkg::wordT  instruction;
  procPkg::wordT  nextPc;
  procPkg::wordT  rsData;
  procPkg::wordT  rtData;
  procPkg::wordT  immExt;
  procPkg::wordT  jumpTarget;
  procPkg::wordT  aluResult;
  procPkg::wordT  branchTarget;
  procPkg::wordT  readData;
  procPkg::aluOpT aluOp;
  logic regWrite, regDst, aluSrc, memRead, memWrite, memToReg;
  logic branch, branchOnZero, jump, halt, ctrlErr;
  logic zero, takeBranch, memErr;
  logic unitErr;
  logic stop;
  logic memWriteEn;

  assign unitErr = ctrlErr || memErr;
  assign stop    = halt || unitErr;

  // An instruction completes every cycle out of reset until the core halts
  assign commitValid = arstN && !halted;
  assign commitPc    = pc;
  assign commitInstr = instruction;

  // Faulting instructions leave registers and memory untouched
  assign wbEn       = regWrite && commitValid && !unitErr;
  assign memWriteEn = memWrite && commitValid && !ctrlErr;

  instrFetch #(
    .ImemDepth(ImemDepth)
  ) fetch_i (
    .clk(clk), .arstN(arstN), .nextPc(nextPc), .stop(stop),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .pc(pc), .instruction(instruction), .halted(halted)
  );

  instrDecode decode_i (
    .clk(clk), .arstN(arstN), .instruction(instruction),
    .regWrite(wbEn), .regDst(regDst), .writeData(wbData),
    .rsData(rsData), .rtData(rtData), .immExt(immExt),
    .jumpTarget(jumpTarget), .wbAddr(wbAddr)
  );

  control control_i (
    .instruction(instruction),
    .regWrite(regWrite), .regDst(regDst), .aluSrc(aluSrc),
    .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
    .branch(branch), .branchOnZero(branchOnZero), .jump(jump),
    .halt(halt), .aluOp(aluOp), .ctrlErr(ctrlErr)
  );

  execute execute_i (
    .aluOp(aluOp), .aluSrc(aluSrc), .rsData(rsData), .rtData(rtData),
    .immExt(immExt), .jumpTarget(jumpTarget), .jump(jump), .pc(pc),
    .aluResult(aluResult), .zero(zero), .branchTarget(branchTarget)
  );

  // ST writes rd, which sits in the rt field of the I-type format
  dataMem #(
    .DmemDepth(DmemDepth)
  ) dataMem_i (
    .clk(clk), .memRead(memRead), .memWrite(memWriteEn), .addr(aluResult),
    .writeData(rtData), .branch(branch), .branchOnZero(branchOnZero), .zero(zero),
    .readData(readData), .takeBranch(takeBranch), .memErr(memErr)
  );

  writeBack writeBack_i (
    .memToReg(memToReg), .readData(readData), .aluResult(aluResult), .pc(pc),
    .branchTarget(branchTarget), .takeBranch(takeBranch), .jump(jump),
    .wbData(wbData), .nextPc(nextPc)
  );

  // Sticky until the next reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      err <= 1'b0;
    end else if (commitValid && unitErr) begin
      err <= 1'b1;
    end
  end

  // Once stopped, fetch stays stopped until reset
  haltIsFinal: assert property (@(posedge clk) disable iff (!arstN)
    halted |=> halted);

endmodule

`default_nettype wire

//--- tb_proc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_proc;

  localparam int ImemDepth   = 256;
  localparam int DmemDepth   = 256;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 5;
  localparam int MaxProgLen  = 64;
  localparam int MaxRunLen   = 100;
  // Seven program runs, each bounded by load, run and drain, plus slack
  localparam int WatchdogCycles = 7 * (MaxProgLen + MaxRunLen + ResetCycles + 8) + 50;

  logic             clk;
  logic             arstN;
  logic             imemWe;
  procPkg::wordT    imemAddr;
  procPkg::wordT    imemData;
  logic             commitValid;
  procPkg::wordT    commitPc;
  procPkg::wordT    commitInstr;
  logic             wbEn;
  procPkg::regAddrT wbAddr;
  procPkg::wordT    wbData;
  logic             halted;
  logic             err;

  // Program under test and the ISA model state
  procPkg::wordT prog[$];
  procPkg::wordT mPc;
  procPkg::wordT mRegs [8];
  procPkg::wordT mDmem [DmemDepth];
  logic [31:0]   rngState;

  proc #(
    .ImemDepth(ImemDepth),
    .DmemDepth(DmemDepth)
  ) dut_i (
    .clk(clk), .arstN(arstN), .imemWe(imemWe), .imemAddr(imemAddr),
    .imemData(imemData), .commitValid(commitValid), .commitPc(commitPc),
    .commitInstr(commitInstr), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
    .halted(halted), .err(err)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles before all tests finished", WatchdogCycles);
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Instruction encoders
  function automatic procPkg::wordT encI(input logic [4:0] op, input int rs, input int rd,
                                         input int imm);
    return {op, 3'(rs), 3'(rd), 5'(imm)};
  endfunction

  function automatic procPkg::wordT encR(input logic [4:0] op, input int fn, input int rs,
                                         input int rt, input int rd);
    return {op, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
  endfunction

  function automatic procPkg::wordT encB(input logic [4:0] op, input int rs, input int off);
    return {op, 3'(rs), 8'(off)};
  endfunction

  function automatic procPkg::wordT encJ(input int off);
    return {procPkg::OpJ, 11'(off)};
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input procPkg::wordT expected,
                           input procPkg::wordT actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkReg(input string name, input procPkg::regAddrT expected,
                          input procPkg::regAddrT actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // ISA reference model, one instruction per call
  task automatic modelStep(input procPkg::wordT instr, output logic expWbEn,
                           output procPkg::regAddrT expAddr, output procPkg::wordT expData,
                           output logic expStop, output logic expErr);
    procPkg::wordT a;
    procPkg::wordT b;
    procPkg::wordT imm5;
    procPkg::wordT off8;
    procPkg::wordT addr;
    procPkg::wordT pcNext;
    a       = mRegs[instr[10:8]];
    b       = mRegs[instr[7:5]];
    imm5    = {{11{instr[4]}}, instr[4:0]};
    off8    = {{8{instr[7]}}, instr[7:0]};
    addr    = a + imm5;
    pcNext  = mPc + 16'd1;
    expWbEn = 1'b0;
    expAddr = instr[7:5];
    expData = '0;
    expStop = 1'b0;
    expErr  = 1'b0;
    case (instr[15:11])
      procPkg::OpHalt: expStop = 1'b1;
      procPkg::OpNop:  ;
      procPkg::OpJ:    pcNext = mPc + 16'd1 + {{5{instr[10]}}, instr[10:0]};
      procPkg::OpAddi: begin
        expWbEn = 1'b1;
        expData = a + imm5;
      end
      procPkg::OpSubi: begin
        expWbEn = 1'b1;
        expData = a - imm5;
      end
      procPkg::OpXori: begin
        expWbEn = 1'b1;
        expData = a ^ imm5;
      end
      procPkg::OpAndni: begin
        expWbEn = 1'b1;
        expData = a & ~imm5;
      end
      procPkg::OpBeqz: begin
        if (a == '0) begin
          pcNext = mPc + 16'd1 + off8;
        end
      end
      procPkg::OpBnez: begin
        if (a != '0) begin
          pcNext = mPc + 16'd1 + off8;
        end
      end
      procPkg::OpSt: begin
        if (addr >= DmemDepth) expErr = 1'b1;
        else mDmem[addr] = b;
      end
      procPkg::OpLd: begin
        if (addr >= DmemDepth) begin
          expErr = 1'b1;
        end else begin
          expWbEn = 1'b1;
          expData = mDmem[addr];
        end
      end
      procPkg::OpRtype, procPkg::OpSlt: begin
        expWbEn = 1'b1;
        expAddr = instr[4:2];
        if (instr[15:11] == procPkg::OpSlt) expData = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        else if (instr[1:0] == 2'b00) expData = a + b;
        else if (instr[1:0] == 2'b01) expData = a - b;
        else if (instr[1:0] == 2'b10) expData = a ^ b;
        else expData = a & ~b;
      end
      default: expErr = 1'b1;
    endcase
    if (expErr) expStop = 1'b1;
    if (expWbEn) mRegs[expAddr] = expData;
    mPc = pcNext;
  endtask

  // Hold reset, write the program one word per clock, then release
  task automatic loadProgram();
    if (prog.size() > MaxProgLen) abortRun("Program is longer than the load budget");
    @(posedge clk);
    arstN <= 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      imemWe   <= 1'b1;
      imemAddr <= procPkg::wordT'(i);
      imemData <= prog[i];
    end
    @(posedge clk);
    imemWe <= 1'b0;
    for (int c = prog.size() + 1; c < ResetCycles; c++) @(posedge clk);
    @(posedge clk);
    arstN <= 1'b1;
  endtask

  task automatic runProgram(input string testName);
    procPkg::wordT    instr;
    procPkg::wordT    expData;
    procPkg::regAddrT expAddr;
    logic             expWbEn;
    logic             expStop;
    logic             expErr;
    int               commits;
    loadProgram();
    mPc     = '0;
    mRegs   = '{default: '0};
    expStop = 1'b0;
    commits = 0;
    while (!expStop) begin
      @(negedge clk);
      if (commits >= MaxRunLen) abortRun({testName, ": program did not reach HALT"});
      if (mPc >= prog.size()) abortRun({testName, ": model PC left the loaded program"});
      instr = prog[mPc];
      checkBit("commitValid", 1'b1, commitValid);
      checkBit("halted", 1'b0, halted);
      checkBit("err", 1'b0, err);
      checkWord("commitPc", mPc, commitPc);
      checkWord("commitInstr", instr, commitInstr);
      modelStep(instr, expWbEn, expAddr, expData, expStop, expErr);
      checkBit("wbEn", expWbEn, wbEn);
      if (expWbEn) begin
        checkReg("wbAddr", expAddr, wbAddr);
        checkWord("wbData", expData, wbData);
      end
      commits++;
    end
    // Stopped core stays quiet
    repeat (3) begin
      @(negedge clk);
      checkBit("commitValid", 1'b0, commitValid);
      checkBit("halted", 1'b1, halted);
      checkBit("wbEn", 1'b0, wbEn);
      checkBit("err", expErr, err);
    end
    $display("%s: %0d commits checked", testName, commits);
  endtask

  task automatic testAlu();
    prog = '{encI(procPkg::OpAddi, 0, 1, 7), encI(procPkg::OpAddi, 0, 2, -3),
             encI(procPkg::OpSubi, 1, 3, -5), encI(procPkg::OpXori, 1, 4, -1),
             encI(procPkg::OpAndni, 2, 5, 5), encR(procPkg::OpRtype, 0, 1, 2, 6),
             encR(procPkg::OpRtype, 1, 1, 3, 7), encR(procPkg::OpRtype, 2, 3, 4, 6),
             encR(procPkg::OpRtype, 3, 4, 1, 5), encR(procPkg::OpSlt, 0, 2, 1, 7),
             encR(procPkg::OpSlt, 0, 1, 2, 6), encR(procPkg::OpSlt, 0, 2, 2, 0),
             {procPkg::OpNop, 11'd0}, {procPkg::OpHalt, 11'd0}};
    runProgram("ALU");
  endtask

  task automatic testMemory();
    prog = '{encI(procPkg::OpAddi, 0, 1, 9), encI(procPkg::OpAddi, 0, 2, -7),
             encI(procPkg::OpAddi, 0, 3, 12), encI(procPkg::OpSt, 3, 1, 0),
             encI(procPkg::OpSt, 3, 2, 3), encI(procPkg::OpSt, 0, 2, 1),
             encI(procPkg::OpAddi, 0, 4, 15), encI(procPkg::OpSt, 3, 4, -12),
             encI(procPkg::OpLd, 3, 5, 0), encI(procPkg::OpLd, 3, 6, 3),
             encI(procPkg::OpLd, 0, 7, 1), encI(procPkg::OpLd, 0, 1, 0),
             {procPkg::OpHalt, 11'd0}};
    runProgram("Memory");
  endtask

  task automatic testBranches();
    // Count-down loop, a taken BEQZ, then forward and backward jumps
    prog = '{encI(procPkg::OpAddi, 0, 1, 3), encB(procPkg::OpBeqz, 1, 2),
             encI(procPkg::OpAddi, 2, 2, 1), encI(procPkg::OpSubi, 1, 1, 1),
             encB(procPkg::OpBnez, 1, -4), encB(procPkg::OpBeqz, 1, 2),
             encI(procPkg::OpAddi, 0, 3, 1), encI(procPkg::OpAddi, 0, 3, 2),
             encJ(3), encI(procPkg::OpAddi, 0, 5, 4), encB(procPkg::OpBnez, 5, 3),
             {procPkg::OpHalt, 11'd0}, encI(procPkg::OpAddi, 0, 4, 6), encJ(-5),
             {procPkg::OpHalt, 11'd0}};
    runProgram("Branches");
  endtask

  task automatic testHalt();
    prog = '{encI(procPkg::OpAddi, 0, 1, 1), {procPkg::OpHalt, 11'd0},
             encI(procPkg::OpAddi, 0, 2, 2), encI(procPkg::OpAddi, 0, 3, 3)};
    runProgram("Halt");
  endtask

  task automatic testErrors();
    prog = '{encI(procPkg::OpAddi, 0, 1, 5), encI(5'b11111, 0, 1, 4),
             encI(procPkg::OpAddi, 0, 2, 2)};
    runProgram("Illegal opcode");
    // Double r1 up to the first address past the data memory
    prog = '{encI(procPkg::OpAddi, 0, 1, 1)};
    for (int v = 1; v < DmemDepth; v = v * 2) prog.push_back(encR(procPkg::OpRtype, 0, 1, 1, 1));
    prog.push_back(encI(procPkg::OpLd, 1, 2, 0));
    prog.push_back(encI(procPkg::OpAddi, 0, 3, 3));
    runProgram("Load out of range");
  endtask

  task automatic testRandom();
    int          addrs[$];
    logic [31:0] r;
    int          kind;
    int          addr;
    prog.delete();
    // r7 stays zero and serves as the memory base
    for (int i = 0; i < 60; i++) begin
      rngState = xorshift32(rngState);
      r        = rngState;
      kind     = r[2:0];
      if (kind == 7 && addrs.size() == 0) kind = 6;
      case (kind)
        0, 1, 2, 3: prog.push_back(encI({3'b010, r[4:3]}, r[7:5], r[10:8] % 7, r[15:11]));
        4: prog.push_back(encR(procPkg::OpRtype, r[4:3], r[7:5], r[10:8], r[13:11] % 7));
        5: prog.push_back(encR(procPkg::OpSlt, 0, r[7:5], r[10:8], r[13:11] % 7));
        6: begin
          addr = r[6:3];
          addrs.push_back(addr);
          prog.push_back(encI(procPkg::OpSt, 7, r[9:7], addr));
        end
        default: begin
          addr = addrs[r[10:3] % addrs.size()];
          prog.push_back(encI(procPkg::OpLd, 7, r[13:11] % 7, addr));
        end
      endcase
    end
    prog.push_back({procPkg::OpHalt, 11'd0});
    runProgram("Random");
  endtask

  initial begin
    arstN    = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    rngState = 32'd60669;
    repeat (ResetCycles) @(posedge clk);
    testAlu();
    testMemory();
    testBranches();
    testHalt();
    testErrors();
    testRandom();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
procPkg.sv
instrFetch.sv
instrDecode.sv
control.sv
execute.sv
dataMem.sv
writeBack.sv
proc.sv
tb_proc.sv

//--- Bender.yml
package:
  name: proc

sources:
  - procPkg.sv
  - instrFetch.sv
  - instrDecode.sv
  - control.sv
  - execute.sv
  - dataMem.sv
  - writeBack.sv
  - proc.sv
  - target: test
    files:
      - tb_proc.sv
